/* sim.f */
+incdir+testbench
rtl/mips_pkg.sv
rtl/pipe_stage_reg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/regfile.sv
rtl/exec_unit.sv
rtl/hazard_unit.sv
rtl/data_mem.sv
rtl/mips_core.sv
testbench/tb_mips_core.sv

/* testbench/tb_program.svh */
// program image and expected retirement sequence, included inside the core testbench module
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int EXP_LEN = 22;

// R-type reads as "op rd, rs, rt"
function automatic word_t enc_r(funct_t fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

// I-type reads as "op rt, rs, imm" and for memory ops as "op rt, imm(rs)"
function automatic word_t enc_i(opcode_t op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t enc_j(word_t target);
    return {OP_J, target[27:2]};
endfunction

function automatic retire_t make_retire(word_t pc, logic wr_en, reg_addr_t rd, word_t data);
    return '{pc: pc, wr_en: wr_en, rd: rd, data: data};
endfunction

// instruction memory contents by word index, NOP_INSTR beyond the last entry
function automatic word_t prog_word(word_t addr);
    int unsigned idx;
    idx = addr >> 2;
    case (idx)
        // dependent ALU chain, every operand comes from the previous one or two results
        0:  return enc_i(OP_ADDIU, 5'd1, 5'd0, 16'h00F3);
        1:  return enc_i(OP_ADDIU, 5'd2, 5'd1, 16'h0125);
        2:  return enc_r(FN_ADDU, 5'd3, 5'd1, 5'd2);
        3:  return enc_r(FN_SUBU, 5'd4, 5'd1, 5'd3);
        4:  return enc_r(FN_AND, 5'd5, 5'd4, 5'd3);
        5:  return enc_r(FN_OR, 5'd6, 5'd5, 5'd2);
        6:  return enc_r(FN_SLT, 5'd7, 5'd4, 5'd6);
        7:  return enc_r(FN_SLT, 5'd8, 5'd6, 5'd4);
        // store, load back from the same word, then use the load at once
        8:  return enc_i(OP_ADDIU, 5'd9, 5'd6, 16'hFFF8);
        9:  return enc_i(OP_SW, 5'd5, 5'd9, 16'h0004);
        10: return enc_i(OP_LW, 5'd10, 5'd9, 16'h0004);
        11: return enc_r(FN_ADDU, 5'd11, 5'd10, 5'd1);
        // taken BEQ skips words 13 and 14
        12: return enc_i(OP_BEQ, 5'd11, 5'd11, 16'h0002);
        13: return enc_i(OP_ADDIU, 5'd12, 5'd0, 16'h0BAD);
        14: return enc_i(OP_ADDIU, 5'd12, 5'd0, 16'h0BAE);
        15: return enc_i(OP_ADDIU, 5'd12, 5'd0, 16'h0055);
        16: return enc_i(OP_BNE, 5'd10, 5'd5, 16'h0004);
        17: return enc_i(OP_ADDIU, 5'd13, 5'd12, 16'h0001);
        // jump to word 21, word 19 is fetched and dropped
        18: return enc_j(32'h0000_0054);
        19: return enc_i(OP_ADDIU, 5'd14, 5'd0, 16'h0BAD);
        20: return enc_i(OP_ADDIU, 5'd14, 5'd0, 16'h0BAE);
        21: return enc_i(OP_ADDIU, 5'd14, 5'd13, 16'h0100);
        // register 0 is written but always reads as zero
        22: return enc_i(OP_ADDIU, 5'd0, 5'd14, 16'h0077);
        23: return enc_r(FN_ADDU, 5'd15, 5'd0, 5'd14);
        24: return enc_r(FN_SUBU, 5'd16, 5'd14, 5'd0);
        default: return NOP_INSTR;
    endcase
endfunction

// retirement records in order, branch and jump shadows left out
function automatic retire_t exp_record(int idx);
    case (idx)
        0:  return make_retire(32'h0000_0000, 1'b1, 5'd1, 32'h0000_00F3);
        1:  return make_retire(32'h0000_0004, 1'b1, 5'd2, 32'h0000_0218);
        2:  return make_retire(32'h0000_0008, 1'b1, 5'd3, 32'h0000_030B);
        3:  return make_retire(32'h0000_000C, 1'b1, 5'd4, 32'hFFFF_FDE8);
        4:  return make_retire(32'h0000_0010, 1'b1, 5'd5, 32'h0000_0108);
        5:  return make_retire(32'h0000_0014, 1'b1, 5'd6, 32'h0000_0318);
        6:  return make_retire(32'h0000_0018, 1'b1, 5'd7, 32'h0000_0001);
        7:  return make_retire(32'h0000_001C, 1'b1, 5'd8, 32'h0000_0000);
        8:  return make_retire(32'h0000_0020, 1'b1, 5'd9, 32'h0000_0310);
        // a store reports its address as data
        9:  return make_retire(32'h0000_0024, 1'b0, 5'd5, 32'h0000_0314);
        10: return make_retire(32'h0000_0028, 1'b1, 5'd10, 32'h0000_0108);
        11: return make_retire(32'h0000_002C, 1'b1, 5'd11, 32'h0000_01FB);
        // branches report the operand difference
        12: return make_retire(32'h0000_0030, 1'b0, 5'd11, 32'h0000_0000);
        13: return make_retire(32'h0000_003C, 1'b1, 5'd12, 32'h0000_0055);
        14: return make_retire(32'h0000_0040, 1'b0, 5'd10, 32'h0000_0000);
        15: return make_retire(32'h0000_0044, 1'b1, 5'd13, 32'h0000_0056);
        16: return make_retire(32'h0000_0048, 1'b0, 5'd0, 32'h0000_0000);
        17: return make_retire(32'h0000_0054, 1'b1, 5'd14, 32'h0000_0156);
        18: return make_retire(32'h0000_0058, 1'b1, 5'd0, 32'h0000_01CD);
        19: return make_retire(32'h0000_005C, 1'b1, 5'd15, 32'h0000_0156);
        20: return make_retire(32'h0000_0060, 1'b1, 5'd16, 32'h0000_0156);
        // first filler word past the program
        21: return make_retire(32'h0000_0064, 1'b0, 5'd0, 32'h0000_0000);
        default: return '0;
    endcase
endfunction

`endif

/* testbench/tb_mips_core.sv */
// testbench for the pipelined core: clock, reset, instruction memory model and retirement checks
`timescale 1ns/1ps

module tb_mips_core;
    import mips_pkg::*;

    localparam word_t RESET_PC    = 32'h0000_0000;
    localparam int    WAIT_CYCLES = 50;

    logic    clk;
    logic    arst_n;
    word_t   imem_addr;
    word_t   imem_data;
    logic    retire_valid;
    retire_t retire_rec;

    `include "tb_program.svh"

    always #20 clk = ~clk;

    // instruction memory answers the current fetch address combinationally
    assign imem_data = prog_word(imem_addr);

    mips_core #(
        .RESET_PC   (RESET_PC),
        .DMEM_WORDS (256)
    ) mips_core_inst (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .retire_valid_o (retire_valid),
        .retire_o       (retire_rec)
    );

    task automatic compare_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "bit compare failed");
        end
    endtask

    task automatic compare_retire(string name, retire_t got, retire_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("  got      pc=%h wr_en=%b rd=%0d data=%h",
                     got.pc, got.wr_en, got.rd, got.data);
            $display("  expected pc=%h wr_en=%b rd=%0d data=%h",
                     exp.pc, exp.wr_en, exp.rd, exp.data);
            $display("** FAIL **");
            $fatal(1, "retirement compare failed");
        end
    endtask

    // samples on the falling edge, so every record is seen once and stable
    task automatic wait_retire(int idx);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (retire_valid !== 1'b1 && cycles < WAIT_CYCLES);
        if (retire_valid !== 1'b1) begin
            $display("timeout: record %0d did not retire within %0d cycles", idx, WAIT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "retirement timeout");
        end
    endtask

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // the first fetch comes from the reset address and nothing retires for four stages
        @(negedge clk);
        compare_word("imem_addr_o", imem_addr, RESET_PC);
        compare_bit("retire_valid_o", retire_valid, 1'b0);
        repeat (3) begin
            @(negedge clk);
            compare_bit("retire_valid_o", retire_valid, 1'b0);
        end

        for (int i = 0; i < EXP_LEN; i++) begin
            wait_retire(i);
            compare_retire("retire_o", retire_rec, exp_record(i));
        end

        $display("** PASS **");
        $finish;
    end

endmodule

/* rtl/mips_core.sv */
// five-stage pipeline top level, connects the stages and exposes fetch and retirement ports
`timescale 1ns/1ps

module mips_core #(
    parameter mips_pkg::word_t RESET_PC   = '0,
    parameter int              DMEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              arst_n_i,
    output mips_pkg::word_t   imem_addr_o,
    input  mips_pkg::word_t   imem_data_i,
    output logic              retire_valid_o,
    output mips_pkg::retire_t retire_o
);
    import mips_pkg::*;

    word_t        pc;
    word_t        next_pc;
    iss_payload_t iss_d;
    iss_payload_t iss_q;
    logic         iss_valid;

    ctrl_t        dec_ctrl;
    reg_addr_t    dec_rs;
    reg_addr_t    dec_rt;
    reg_addr_t    dec_rd;
    word_t        dec_imm;
    word_t        dec_brn_target;
    word_t        rs_data;
    word_t        rt_data;
    redirect_t    jump_redirect;
    redirect_t    branch_redirect;

    ex_payload_t  ex_d;
    ex_payload_t  ex_q;
    logic         ex_valid;
    mem_payload_t mem_d;
    mem_payload_t mem_q;
    logic         mem_valid;
    wb_payload_t  wb_d;
    wb_payload_t  wb_q;
    logic         wb_valid;
    word_t        dmem_rd_data;

    logic         stall;
    logic         flush_iss;
    logic         flush_ex;
    fwd_sel_t     fwd_a;
    fwd_sel_t     fwd_b;

    fetch_unit #(.RESET_PC(RESET_PC)) fetch_inst (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .stall_i           (stall),
        .branch_redirect_i (branch_redirect),
        .jump_redirect_i   (jump_redirect),
        .pc_o              (pc),
        .next_pc_o         (next_pc)
    );

    assign imem_addr_o = pc;
    assign iss_d       = '{pc: pc, next_pc: next_pc, instr: imem_data_i};

    // fetch always delivers an instruction, so the issue input is always valid
    pipe_stage_reg #(.payload_t(iss_payload_t)) iss_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (stall),
        .flush_i  (flush_iss),
        .valid_i  (1'b1),
        .data_i   (iss_d),
        .valid_o  (iss_valid),
        .data_o   (iss_q)
    );

    decode_unit decode_inst (
        .valid_i         (iss_valid),
        .iss_i           (iss_q),
        .ctrl_o          (dec_ctrl),
        .rs_o            (dec_rs),
        .rt_o            (dec_rt),
        .rd_o            (dec_rd),
        .imm_o           (dec_imm),
        .brn_target_o    (dec_brn_target),
        .jump_redirect_o (jump_redirect)
    );

    regfile regfile_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rd_addr_a_i (dec_rs),
        .rd_addr_b_i (dec_rt),
        .rd_data_a_o (rs_data),
        .rd_data_b_o (rt_data),
        .wr_en_i     (wb_valid && wb_q.reg_wr),
        .wr_addr_i   (wb_q.rd),
        .wr_data_i   (wb_q.data)
    );

    assign ex_d = '{
        ctrl:       dec_ctrl,
        rs:         dec_rs,
        rt:         dec_rt,
        rd:         dec_rd,
        rs_data:    rs_data,
        rt_data:    rt_data,
        imm:        dec_imm,
        brn_target: dec_brn_target,
        pc:         iss_q.pc
    };

    pipe_stage_reg #(.payload_t(ex_payload_t)) ex_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .flush_i  (flush_ex),
        .valid_i  (iss_valid),
        .data_i   (ex_d),
        .valid_o  (ex_valid),
        .data_o   (ex_q)
    );

    exec_unit exec_inst (
        .valid_i           (ex_valid),
        .ex_i              (ex_q),
        .fwd_a_i           (fwd_a),
        .fwd_b_i           (fwd_b),
        .mem_fwd_i         (mem_q.alu_res),
        .wb_fwd_i          (wb_q.data),
        .mem_o             (mem_d),
        .branch_redirect_o (branch_redirect)
    );

    pipe_stage_reg #(.payload_t(mem_payload_t)) mem_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .flush_i  (1'b0),
        .valid_i  (ex_valid),
        .data_i   (mem_d),
        .valid_o  (mem_valid),
        .data_o   (mem_q)
    );

    data_mem #(.DMEM_WORDS(DMEM_WORDS)) dmem_inst (
        .clk       (clk),
        .wr_en_i   (mem_valid && mem_q.mem_wr),
        .addr_i    (mem_q.alu_res),
        .wr_data_i (mem_q.store_data),
        .rd_data_o (dmem_rd_data)
    );

    assign wb_d = '{
        reg_wr: mem_q.reg_wr,
        rd:     mem_q.rd,
        data:   mem_q.mem_rd ? dmem_rd_data : mem_q.alu_res,
        pc:     mem_q.pc
    };

    pipe_stage_reg #(.payload_t(wb_payload_t)) wb_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .flush_i  (1'b0),
        .valid_i  (mem_valid),
        .data_i   (wb_d),
        .valid_o  (wb_valid),
        .data_o   (wb_q)
    );

    hazard_unit hazard_inst (
        .ex_valid_i     (ex_valid),
        .ex_rs_i        (ex_q.rs),
        .ex_rt_i        (ex_q.rt),
        .ex_mem_rd_i    (ex_q.ctrl.mem_rd),
        .ex_rd_i        (ex_q.rd),
        .dec_rs_i       (dec_rs),
        .dec_rt_i       (dec_rt),
        .mem_valid_i    (mem_valid),
        .mem_reg_wr_i   (mem_q.reg_wr),
        .mem_rd_i       (mem_q.rd),
        .wb_valid_i     (wb_valid),
        .wb_reg_wr_i    (wb_q.reg_wr),
        .wb_rd_i        (wb_q.rd),
        .jump_taken_i   (jump_redirect.taken),
        .branch_taken_i (branch_redirect.taken),
        .stall_o        (stall),
        .flush_iss_o    (flush_iss),
        .flush_ex_o     (flush_ex),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b)
    );

    // every valid writeback entry retires, bubbles from unknown opcodes included
    assign retire_valid_o = wb_valid;
    assign retire_o       = '{pc: wb_q.pc, wr_en: wb_q.reg_wr, rd: wb_q.rd, data: wb_q.data};

endmodule

/* rtl/data_mem.sv */
// word-wide data memory with clocked write and combinational read for the memory stage
`timescale 1ns/1ps

module data_mem #(
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            wr_en_i,
    input  mips_pkg::word_t addr_i,
    input  mips_pkg::word_t wr_data_i,
    output mips_pkg::word_t rd_data_o
);
    import mips_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    word_t          mem [DMEM_WORDS];
    logic  [AW-1:0] word_idx;

    // byte address to word index
    assign word_idx  = addr_i[AW+1:2];
    assign rd_data_o = mem[word_idx];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[word_idx] <= wr_data_i;
        end
    end

    wr_in_range_a: assert property (@(posedge clk) wr_en_i |-> addr_i[31:2] < DMEM_WORDS);

endmodule

/* rtl/hazard_unit.sv */
// hazard detection: forwarding selects, load-use stall and flushes for jumps and taken branches
`timescale 1ns/1ps

module hazard_unit (
    input  logic                ex_valid_i,
    input  mips_pkg::reg_addr_t ex_rs_i,
    input  mips_pkg::reg_addr_t ex_rt_i,
    input  logic                ex_mem_rd_i,
    input  mips_pkg::reg_addr_t ex_rd_i,
    input  mips_pkg::reg_addr_t dec_rs_i,
    input  mips_pkg::reg_addr_t dec_rt_i,
    input  logic                mem_valid_i,
    input  logic                mem_reg_wr_i,
    input  mips_pkg::reg_addr_t mem_rd_i,
    input  logic                wb_valid_i,
    input  logic                wb_reg_wr_i,
    input  mips_pkg::reg_addr_t wb_rd_i,
    input  logic                jump_taken_i,
    input  logic                branch_taken_i,
    output logic                stall_o,
    output logic                flush_iss_o,
    output logic                flush_ex_o,
    output mips_pkg::fwd_sel_t  fwd_a_o,
    output mips_pkg::fwd_sel_t  fwd_b_o
);
    import mips_pkg::*;

    logic load_use;

    // the memory stage holds the younger result, so it is checked first
    function automatic fwd_sel_t fwd_src(reg_addr_t src);
        if (src == '0) begin
            return FWD_RF;
        end
        if (mem_valid_i && mem_reg_wr_i && mem_rd_i == src) begin
            return FWD_MEM;
        end
        if (wb_valid_i && wb_reg_wr_i && wb_rd_i == src) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    always_comb begin
        fwd_a_o = fwd_src(ex_rs_i);
        fwd_b_o = fwd_src(ex_rt_i);
    end

    assign load_use = ex_valid_i && ex_mem_rd_i && (ex_rd_i != '0) &&
                      (ex_rd_i == dec_rs_i || ex_rd_i == dec_rt_i);

    assign stall_o     = load_use && !branch_taken_i;
    // a jump held by a stall must stay in decode until it can redirect
    assign flush_iss_o = branch_taken_i || (jump_taken_i && !load_use);
    assign flush_ex_o  = branch_taken_i || load_use;

    // a load in execute is never a branch, so a stall request never meets a branch flush
    always_comb begin
        branch_flush_a: assert final (!(branch_taken_i && load_use));
    end

endmodule

/* rtl/exec_unit.sv */
// execute stage: forwarded operand selection, ALU and BEQ/BNE resolution
`timescale 1ns/1ps

module exec_unit (
    input  logic                   valid_i,
    input  mips_pkg::ex_payload_t  ex_i,
    input  mips_pkg::fwd_sel_t     fwd_a_i,
    input  mips_pkg::fwd_sel_t     fwd_b_i,
    input  mips_pkg::word_t        mem_fwd_i,
    input  mips_pkg::word_t        wb_fwd_i,
    output mips_pkg::mem_payload_t mem_o,
    output mips_pkg::redirect_t    branch_redirect_o
);
    import mips_pkg::*;

    word_t op_a;
    word_t rt_val;
    word_t op_b;
    word_t alu_res;

    function automatic word_t fwd_pick(fwd_sel_t sel, word_t rf_val);
        case (sel)
            FWD_MEM: return mem_fwd_i;
            FWD_WB:  return wb_fwd_i;
            default: return rf_val;
        endcase
    endfunction

    always_comb begin
        op_a   = fwd_pick(fwd_a_i, ex_i.rs_data);
        rt_val = fwd_pick(fwd_b_i, ex_i.rt_data);
    end

    assign op_b = ex_i.ctrl.use_imm ? ex_i.imm : rt_val;

    always_comb begin
        case (ex_i.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    // branches run a subtract, so a zero result means the operands are equal
    assign branch_redirect_o.taken  = valid_i &&
                                      ((ex_i.ctrl.branch_eq && alu_res == '0) ||
                                       (ex_i.ctrl.branch_ne && alu_res != '0));
    assign branch_redirect_o.target = ex_i.brn_target;

    assign mem_o = '{
        reg_wr:     ex_i.ctrl.reg_wr,
        mem_rd:     ex_i.ctrl.mem_rd,
        mem_wr:     ex_i.ctrl.mem_wr,
        rd:         ex_i.rd,
        alu_res:    alu_res,
        store_data: rt_val,
        pc:         ex_i.pc
    };

endmodule

/* rtl/regfile.sv */
// 32-entry register file, two combinational read ports with bypass from the write port
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                arst_n_i,
    input  mips_pkg::reg_addr_t rd_addr_a_i,
    input  mips_pkg::reg_addr_t rd_addr_b_i,
    output mips_pkg::word_t     rd_data_a_o,
    output mips_pkg::word_t     rd_data_b_o,
    input  logic                wr_en_i,
    input  mips_pkg::reg_addr_t wr_addr_i,
    input  mips_pkg::word_t     wr_data_i
);
    import mips_pkg::*;

    word_t regs [32];
    logic  wr_live;

    // writes to register 0 are dropped so it always reads zero
    assign wr_live = wr_en_i && (wr_addr_i != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs <= '{default: '0};
        end else if (wr_live) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // the writeback value of this cycle is visible to decode in the same cycle
    assign rd_data_a_o = (wr_live && wr_addr_i == rd_addr_a_i) ? wr_data_i :
                         regs[rd_addr_a_i];
    assign rd_data_b_o = (wr_live && wr_addr_i == rd_addr_b_i) ? wr_data_i :
                         regs[rd_addr_b_i];

    zero_reg_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        (rd_addr_a_i == '0 |-> rd_data_a_o == '0) and (rd_addr_b_i == '0 |-> rd_data_b_o == '0));

endmodule

/* rtl/decode_unit.sv */
// instruction decode: field split, control generation, immediate and jump/branch targets
`timescale 1ns/1ps

module decode_unit (
    input  logic                   valid_i,
    input  mips_pkg::iss_payload_t iss_i,
    output mips_pkg::ctrl_t        ctrl_o,
    output mips_pkg::reg_addr_t    rs_o,
    output mips_pkg::reg_addr_t    rt_o,
    output mips_pkg::reg_addr_t    rd_o,
    output mips_pkg::word_t        imm_o,
    output mips_pkg::word_t        brn_target_o,
    output mips_pkg::redirect_t    jump_redirect_o
);
    import mips_pkg::*;

    logic [5:0] op;
    logic [5:0] funct;

    assign op    = iss_i.instr[31:26];
    assign funct = iss_i.instr[5:0];

    assign rs_o = iss_i.instr[25:21];
    assign rt_o = iss_i.instr[20:16];
    // I-type results go to rt
    assign rd_o = (op == OP_RTYPE) ? iss_i.instr[15:11] : iss_i.instr[20:16];

    assign imm_o        = {{16{iss_i.instr[15]}}, iss_i.instr[15:0]};
    assign brn_target_o = iss_i.next_pc + {imm_o[29:0], 2'b00};

    assign jump_redirect_o.taken  = valid_i && (op == OP_J);
    assign jump_redirect_o.target = {iss_i.next_pc[31:28], iss_i.instr[25:0], 2'b00};

    // anything not listed keeps all control low and passes down as a bubble
    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = ALU_ADD;
        case (op)
            OP_RTYPE: begin
                ctrl_o.reg_wr = 1'b1;
                case (funct)
                    FN_ADDU: ctrl_o.alu_op = ALU_ADD;
                    FN_SUBU: ctrl_o.alu_op = ALU_SUB;
                    FN_AND:  ctrl_o.alu_op = ALU_AND;
                    FN_OR:   ctrl_o.alu_op = ALU_OR;
                    FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    default: ctrl_o.reg_wr = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.reg_wr  = 1'b1;
                ctrl_o.use_imm = 1'b1;
            end
            OP_LW: begin
                ctrl_o.reg_wr  = 1'b1;
                ctrl_o.mem_rd  = 1'b1;
                ctrl_o.use_imm = 1'b1;
            end
            OP_SW: begin
                ctrl_o.mem_wr  = 1'b1;
                ctrl_o.use_imm = 1'b1;
            end
            OP_BEQ: begin
                ctrl_o.branch_eq = 1'b1;
                ctrl_o.alu_op    = ALU_SUB;
            end
            OP_BNE: begin
                ctrl_o.branch_ne = 1'b1;
                ctrl_o.alu_op    = ALU_SUB;
            end
            default: begin
                ctrl_o = '0;
            end
        endcase
    end

endmodule

/* rtl/fetch_unit.sv */
// program counter and next-PC selection, drives the instruction memory address each cycle
`timescale 1ns/1ps

module fetch_unit #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                stall_i,
    input  mips_pkg::redirect_t branch_redirect_i,
    input  mips_pkg::redirect_t jump_redirect_i,
    output mips_pkg::word_t     pc_o,
    output mips_pkg::word_t     next_pc_o
);
    import mips_pkg::*;

    word_t pc_q;

    assign pc_o      = pc_q;
    assign next_pc_o = pc_q + 32'd4;

    // a taken branch in execute overrides everything, the younger jump included
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (branch_redirect_i.taken) begin
            pc_q <= branch_redirect_i.target;
        end else if (!stall_i) begin
            pc_q <= jump_redirect_i.taken ? jump_redirect_i.target : next_pc_o;
        end
    end

    pc_aligned_a: assert property (@(posedge clk) disable iff (!arst_n_i) pc_o[1:0] == 2'b00);

endmodule

/* rtl/pipe_stage_reg.sv */
// generic pipeline register with valid bit, stall hold and flush, one instance per stage payload
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            // a flushed stage turns into a bubble even when held
            valid_o <= 1'b0;
        end else if (!hold_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            data_o <= data_i;
        end
    end

    valid_known_a: assert property (@(posedge clk) disable iff (!arst_n_i) !$isunknown(valid_o));

endmodule

/* rtl/mips_pkg.sv */
// shared word, opcode, control and stage payload types for the pipeline RTL and its testbench
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // function field of R-type instructions, bits 5:0
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef struct packed {
        logic    reg_wr;
        logic    mem_rd;
        logic    mem_wr;
        logic    use_imm;
        logic    branch_ne;
        logic    branch_eq;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t next_pc;
        word_t instr;
    } iss_payload_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        word_t     brn_target;
        word_t     pc;
    } ex_payload_t;

    typedef struct packed {
        logic      reg_wr;
        logic      mem_rd;
        logic      mem_wr;
        reg_addr_t rd;
        word_t     alu_res;
        word_t     store_data;
        word_t     pc;
    } mem_payload_t;

    typedef struct packed {
        logic      reg_wr;
        reg_addr_t rd;
        word_t     data;
        word_t     pc;
    } wb_payload_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        word_t     pc;
        logic      wr_en;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

    localparam word_t NOP_INSTR = 32'h0000_0000;

endpackage
